// ==== Bender.yml ====
package:
  name: ow_uart_master

sources:
  - verilog/ow_uart_pkg.sv
  - verilog/uart_tx_dual_baud.sv
  - verilog/uart_rx_dual_baud.sv
  - verilog/ow_slot_engine.sv
  - verilog/ow_wb_regs.sv
  - verilog/ow_uart_master.sv
  - target: test
    files:
      - dv/ow_uart_tb.sv

// ==== dv/ow_uart_tb.sv ====
`timescale 1ns/1ps

module ow_uart_tb;
	import ow_uart_pkg::*;

	localparam int CLK_FREQ   = 960000;
	localparam int BAUD_FAST  = 96000;                  // 10 clocks per bit
	localparam int BAUD_SLOW  = 48000;                  // 20 clocks per bit
	localparam int FAST_CLKS  = CLK_FREQ / BAUD_FAST;
	localparam int SLOW_CLKS  = CLK_FREQ / BAUD_SLOW;
	localparam int MAX_TESTS  = 64;
	localparam int ACK_LIMIT  = 16;                     // clocks to wait for wb_ack
	localparam int POLL_LIMIT = 1000;                   // status reads before giving up

	// one line of the test file, one hex digit or byte per field
	typedef struct packed {
		logic [3:0] op;
		logic [7:0] wdata;
		logic [3:0] present;
		logic [7:0] answer;
		logic [3:0] dual;                               // second cmd while busy
		logic [3:0] op2;
		logic [7:0] data2;
		logic [3:0] exp_presence;
		logic [7:0] exp_byte;
	} test_line_t;

	logic        sys_clk;
	logic        master_rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        rxd;
	logic        txd;

	logic [51:0] test_mem [MAX_TESTS];
	int          mismatch_count = 0;
	int          fail_count     = 0;                    // timeouts and other failures

	// ************************************************
	// 1-wire device model
	// ************************************************
	logic        pull          = 1'b0;                  // device pulldown
	logic        model_slow    = 1'b0;                  // next frame is a reset
	logic        model_present = 1'b0;
	logic [7:0]  model_answer  = 8'hFF;                 // read answer, lsb first
	logic        in_frame      = 1'b0;
	int          frame_pos     = 0;                     // clocks since start bit
	int          frame_bit     = 0;
	int          bit_clks      = FAST_CLKS;
	logic [7:0]  txd_bits      = 8'h00;
	logic [7:0]  rebuilt       = 8'h00;                 // written byte as the device sees it
	int          slow_frames   = 0;
	int          fast_frames   = 0;

	assign rxd = txd & ~pull;                           // open drain wired and

	ow_uart_master #(.CLK_FREQ(CLK_FREQ), .BAUD_FAST(BAUD_FAST), .BAUD_SLOW(BAUD_SLOW))
		UUT (.sys_clk, .master_rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .rxd, .txd);

	always #4 sys_clk = ~sys_clk;

	always @(negedge sys_clk) begin
		if (!in_frame) begin
			pull = 1'b0;
			if (txd == 1'b0) begin
				in_frame  = 1'b1;                       // start bit seen
				frame_pos = 0;
				bit_clks  = model_slow ? SLOW_CLKS : FAST_CLKS;
				txd_bits  = 8'h00;
			end
		end else begin
			frame_pos = frame_pos + 1;
			frame_bit = frame_pos / bit_clks;
			if ((frame_pos % bit_clks == bit_clks / 2) && (frame_bit >= 1) && (frame_bit <= 8))
				txd_bits[frame_bit - 1] = txd;          // mid data bit
			if (model_slow)
				pull = model_present && (frame_bit >= 5) && (frame_bit <= 7);   // data 4..6
			else
				pull = !model_answer[fast_frames % 8] && (frame_bit >= 2) && (frame_bit <= 4);
			if (frame_pos == 9 * bit_clks + bit_clks / 2) begin
				in_frame = 1'b0;                        // mid stop bit
				pull     = 1'b0;
				if (model_slow) begin
					slow_frames = slow_frames + 1;
				end else begin
					fast_frames = fast_frames + 1;
					rebuilt     = {|txd_bits, rebuilt[7:1]};   // all zero slot is a 0
				end
			end
		end
	end

	// ************************************************
	// wishbone host and compare tasks
	// ************************************************
	task automatic wb_transfer(input logic write, input logic [1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata  = 32'h0;
		@(negedge sys_clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = write;
		wb_adr   = adr;
		wb_dat_w = wdata;
		@(negedge sys_clk);
		while (!wb_ack && (waited < ACK_LIMIT)) begin
			waited++;
			@(negedge sys_clk);
		end
		if (!wb_ack) begin
			$display("timeout: no wb_ack for a transfer to address %0d", adr);
			fail_count++;
		end
		rdata = wb_dat_r;
		@(negedge sys_clk);                             // hold through the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdata);
		logic [31:0] unused;
		wb_transfer(1'b1, adr, wdata, unused);
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdata);
		wb_transfer(1'b0, adr, 32'h0, rdata);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_status(input logic busy_got, input logic presence_got,
		input logic busy_exp, input logic presence_exp);
		if (busy_got !== busy_exp) begin
			$display("MISMATCH busy: got 0x%h expected 0x%h", busy_got, busy_exp);
			mismatch_count++;
		end
		if (presence_got !== presence_exp) begin
			$display("MISMATCH presence: got 0x%h expected 0x%h", presence_got, presence_exp);
			mismatch_count++;
		end
	endtask

	// poll REG_STATUS until busy drops
	task automatic wait_idle(output logic [31:0] status);
		int polls;
		polls = 0;
		wb_read(REG_STATUS, status);
		while (status[0] && (polls < POLL_LIMIT) && (fail_count == 0)) begin
			polls++;
			wb_read(REG_STATUS, status);
		end
		if (status[0] && (fail_count == 0)) begin
			$display("timeout: busy never dropped after a command");
			fail_count++;
		end
	endtask

	task automatic run_test(input test_line_t tl);
		logic [31:0] rd;
		int          slow_before;
		int          fast_before;
		model_slow    = tl.op == 4'h0;
		model_present = tl.present[0];
		model_answer  = tl.answer;
		slow_before   = slow_frames;
		fast_before   = fast_frames;
		wb_write(REG_CMD, {22'd0, tl.op[1:0], tl.wdata});
		if (tl.dual != 4'h0)
			wb_write(REG_CMD, {22'd0, tl.op2[1:0], tl.data2});   // dropped, engine busy
		wait_idle(rd);
		if (fail_count == 0) begin
			check_status(rd[0], rd[1], 1'b0, tl.exp_presence[0]);
			check_byte("slow_frames", 8'(slow_frames - slow_before), {7'd0, model_slow});
			check_byte("fast_frames", 8'(fast_frames - fast_before), model_slow ? 8'd0 : 8'd8);
			wb_read(REG_CMD, rd);                       // still the first command
			check_byte("cmd data", rd[7:0], tl.wdata);
			check_byte("cmd op", {6'd0, rd[9:8]}, {6'd0, tl.op[1:0]});
			if (tl.op == 4'h1)
				check_byte("rebuilt", rebuilt, tl.exp_byte);
			if (tl.op == 4'h2) begin
				wb_read(REG_RDATA, rd);
				check_byte("rdata", rd[7:0], tl.exp_byte);
			end
			wb_read(2'd3, rd);                          // unused address
			for (int b = 0; b < 4; b++)
				check_byte($sformatf("wb_dat_r adr 3 byte %0d", b), rd[8*b +: 8], 8'h00);
		end
	endtask

	initial begin
		int t;
		int idle;
		sys_clk    = 1'b0;
		master_rst = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = 2'd0;
		wb_dat_w   = 32'h0;
		void'($urandom(32'h676b155a));
		for (t = 0; t < MAX_TESTS; t++)
			test_mem[t] = '1;                           // op f marks the end
		$readmemh("dv/ow_uart_tests.txt", test_mem);
		repeat (3) @(negedge sys_clk);
		master_rst = 1'b0;
		t = 0;
		while ((t < MAX_TESTS) && (test_mem[t][51:48] != 4'hF) && (fail_count == 0)) begin
			idle = $urandom_range(12, 2);
			repeat (idle) @(negedge sys_clk);
			run_test(test_line_t'(test_mem[t]));
			t++;
		end
		if (t == 0) begin
			$display("no test lines were read from the test file");
			fail_count++;
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if ((mismatch_count == 0) && (fail_count == 0))
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/ow_uart_tests.txt ====
// op _ wdata _ present _ answer _ dual _ op2 data2 _ exp_presence _ exp_byte
// op 0 reset 1 write 2 read, dual 1 sends op2 data2 while busy, op f ends the list
0_00_1_ff_0_0_00_1_00 // reset, device present
1_a5_1_ff_0_0_00_1_a5 // write a5
2_00_1_3c_0_0_00_1_3c // read mixed pattern
0_00_0_ff_0_0_00_0_00 // reset, no device
2_00_0_00_0_0_00_0_00 // read all zero
2_00_0_ff_0_0_00_0_ff // read all ones
1_00_0_ff_0_0_00_0_00 // write 00
1_ff_0_ff_0_0_00_0_ff // write ff
0_00_1_ff_0_0_00_1_00 // reset, device back
2_00_1_96_0_0_00_1_96 // read 96
1_3c_1_ff_1_2_00_1_3c // write, read while busy dropped
2_00_1_5a_1_1_c3_1_5a // read, write while busy dropped
0_00_0_ff_1_1_55_0_00 // reset absent, write while busy dropped
2_00_0_81_0_0_00_0_81 // read 81
0_00_1_ff_1_2_00_1_00 // reset present, read while busy dropped
1_01_1_ff_0_0_00_1_01 // write lsb only
2_00_1_7e_0_0_00_1_7e // read 7e
1_80_1_ff_0_0_00_1_80 // write msb only
2_00_1_01_0_0_00_1_01 // read lsb only
1_69_1_ff_1_0_00_1_69 // write, reset while busy dropped
2_00_1_e7_0_0_00_1_e7 // read e7
f_00_0_00_0_0_00_0_00 // end of list

// ==== verilog.f ====
verilog/ow_uart_pkg.sv
verilog/uart_tx_dual_baud.sv
verilog/uart_rx_dual_baud.sv
verilog/ow_slot_engine.sv
verilog/ow_wb_regs.sv
verilog/ow_uart_master.sv
dv/ow_uart_tb.sv

// ==== verilog/ow_slot_engine.sv ====
`timescale 1ns/1ps

module ow_slot_engine (
	input  logic                     sys_clk,
	input  logic                     master_rst,
	input  logic                     cmd_start,        // only while idle
	input  ow_uart_pkg::ow_cmd_t     cmd,
	input  logic                     tx_done,
	input  logic                     rx_valid,
	input  logic [7:0]               rx_byte,          // echo of the last slot
	output ow_uart_pkg::ow_rsp_t     rsp,
	output logic                     tx_start,
	output ow_uart_pkg::uart_frame_t tx_frame,
	output logic                     slow_baud
);
	import ow_uart_pkg::*;

	localparam logic [4:0] ECHO_WAIT = 5'd16;          // clocks to wait for echo after tx_done

	typedef enum logic {
		S_IDLE,
		S_SLOT
	} state_e;

	state_e     state;
	ow_op_e     op_q;                                   // current operation
	logic [7:0] data_q;                                 // byte being written
	logic [2:0] bit_idx;                                // slot number, lsb first
	logic       tx_seen;                                // tx_done arrived this slot
	logic       rx_seen;                                // echo arrived this slot
	logic [4:0] echo_cnt;
	logic [7:0] echo_q;                                 // 0x00 when no echo came back
	logic       presence_q;
	logic [7:0] rdata_q;
	logic       done_q;
	logic [7:0] slot_byte;
	logic       slot_end;
	logic       last_slot;
	logic       echo_one;

	// ************************************************
	// slot byte select
	// ************************************************
	always_comb begin
		case (op_q)
			OP_RESET: slot_byte = FRAME_RESET;
			OP_WRITE: slot_byte = data_q[bit_idx] ? FRAME_ONE : FRAME_ZERO;
			default:  slot_byte = FRAME_ONE;            // read slot releases early
		endcase
	end

	assign tx_frame  = {1'b1, slot_byte, 1'b0};         // stop, data, start
	assign slot_end  = (state == S_SLOT) && tx_seen && (rx_seen || (echo_cnt == ECHO_WAIT));
	assign last_slot = (op_q == OP_RESET) || (bit_idx == 3'd7);
	assign echo_one  = echo_q == FRAME_ONE;             // any pulldown reads as 0
	assign rsp       = '{presence: presence_q, rdata: rdata_q, done: done_q};

	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			state      <= S_IDLE;
			tx_start   <= 1'b0;
			done_q     <= 1'b0;
			slow_baud  <= 1'b0;
			bit_idx    <= 3'd0;
			tx_seen    <= 1'b0;
			rx_seen    <= 1'b0;
			echo_cnt   <= 5'd0;
			presence_q <= 1'b0;
			rdata_q    <= 8'h00;
		end else begin
			tx_start <= 1'b0;
			done_q   <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmd_start) begin
						bit_idx   <= 3'd0;
						tx_seen   <= 1'b0;
						rx_seen   <= 1'b0;
						echo_cnt  <= 5'd0;
						slow_baud <= cmd.op == OP_RESET;   // reset pulse needs the long bit
						if (cmd.op == OP_NONE) begin
							done_q <= 1'b1;             // nothing to send
						end else begin
							state    <= S_SLOT;
							tx_start <= 1'b1;
						end
					end
				end
				S_SLOT: begin
					if (tx_done)
						tx_seen <= 1'b1;
					if (rx_valid)
						rx_seen <= 1'b1;
					if (tx_seen && !rx_seen)
						echo_cnt <= echo_cnt + 5'd1;    // echo timeout
					if (slot_end) begin
						tx_seen  <= 1'b0;
						rx_seen  <= 1'b0;
						echo_cnt <= 5'd0;
						if (op_q == OP_RESET)
							presence_q <= echo_q != FRAME_RESET;
						if (op_q == OP_READ)
							rdata_q <= {echo_one, rdata_q[7:1]};
						if (last_slot) begin
							state  <= S_IDLE;
							done_q <= 1'b1;
						end else begin
							bit_idx  <= bit_idx + 3'd1;
							tx_start <= 1'b1;           // next slot
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if ((state == S_IDLE) && cmd_start) begin
			op_q   <= cmd.op;
			data_q <= cmd.data;
		end
		if (tx_start)
			echo_q <= 8'h00;                            // stays zero if no echo comes back
		else if (rx_valid && (state == S_SLOT))
			echo_q <= rx_byte;
	end

	a_one_frame: assert property (@(posedge sys_clk) disable iff (master_rst)
		tx_start |=> (!tx_start throughout tx_done[->1]))
		else $error("tx_start while a frame is in flight");

	a_start_idle: assert property (@(posedge sys_clk) disable iff (master_rst)
		cmd_start |-> (state == S_IDLE))
		else $error("cmd_start while engine busy");

endmodule

// ==== verilog/ow_uart_master.sv ====
`timescale 1ns/1ps

module ow_uart_master #(
	parameter int CLK_FREQ  = 960000,
	parameter int BAUD_FAST = 96000,                    // bit slots
	parameter int BAUD_SLOW = 48000                     // reset pulse
) (
	input  logic        sys_clk,
	input  logic        master_rst,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	input  logic        rxd,                            // bus level read back
	output logic        txd                             // drives the bus pulldown
);
	import ow_uart_pkg::*;

	ow_cmd_t     cmd;
	ow_rsp_t     rsp;
	logic        cmd_start;
	logic        tx_start;
	logic        tx_done;
	logic        slow_baud;
	uart_frame_t tx_frame;
	logic        rx_valid;
	logic [7:0]  rx_byte;

	ow_wb_regs u_regs (.sys_clk, .master_rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_w, .rsp, .wb_dat_r, .wb_ack, .cmd, .cmd_start);

	ow_slot_engine u_engine (.sys_clk, .master_rst, .cmd_start, .cmd, .tx_done,
		.rx_valid, .rx_byte, .rsp, .tx_start, .tx_frame, .slow_baud);

	uart_tx_dual_baud #(.CLK_FREQ(CLK_FREQ), .BAUD_FAST(BAUD_FAST), .BAUD_SLOW(BAUD_SLOW))
		u_tx (.sys_clk, .master_rst, .tx_start, .slow_baud, .tx_frame, .tx_done, .txd);

	uart_rx_dual_baud #(.CLK_FREQ(CLK_FREQ), .BAUD_FAST(BAUD_FAST), .BAUD_SLOW(BAUD_SLOW))
		u_rx (.sys_clk, .master_rst, .slow_baud, .rxd, .rx_valid, .rx_byte);

endmodule

// ==== verilog/ow_uart_pkg.sv ====
package ow_uart_pkg;

	// ************************************************
	// operation codes and bus transfer types
	// ************************************************

	typedef enum logic [1:0] {
		OP_RESET = 2'd0,                 // reset pulse plus presence detect
		OP_WRITE = 2'd1,                 // write one byte lsb first
		OP_READ  = 2'd2,                 // read one byte lsb first
		OP_NONE  = 2'd3                  // no bus activity
	} ow_op_e;

	typedef struct packed {
		ow_op_e     op;                  // bits 9:8 of the cmd word
		logic [7:0] data;                // byte to write
	} ow_cmd_t;

	typedef struct packed {
		logic       presence;            // device answered the last reset
		logic [7:0] rdata;               // last byte read from the bus
		logic       done;                // one cycle pulse at end of op
	} ow_rsp_t;

	// start bit in bit 0, stop bit in bit 9
	typedef logic [9:0] uart_frame_t;

	// ************************************************
	// register map and slot bytes
	// ************************************************

	localparam logic [1:0] REG_CMD    = 2'd0;  // write starts an op
	localparam logic [1:0] REG_STATUS = 2'd1;  // busy in bit 0, presence in bit 1
	localparam logic [1:0] REG_RDATA  = 2'd2;  // last read byte

	localparam logic [7:0] FRAME_RESET = 8'hF0; // long low then release at slow rate
	localparam logic [7:0] FRAME_ONE   = 8'hFF; // short low pulse only
	localparam logic [7:0] FRAME_ZERO  = 8'h00; // low for the whole slot

endpackage

// ==== verilog/ow_wb_regs.sv ====
`timescale 1ns/1ps

module ow_wb_regs (
	input  logic                 sys_clk,
	input  logic                 master_rst,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [1:0]           wb_adr,                // word address
	input  logic [31:0]          wb_dat_w,
	input  ow_uart_pkg::ow_rsp_t rsp,
	output logic [31:0]          wb_dat_r,
	output logic                 wb_ack,
	output ow_uart_pkg::ow_cmd_t cmd,
	output logic                 cmd_start              // same cycle as ack
);
	import ow_uart_pkg::*;

	logic       wb_req;                                 // new classic request
	logic       cmd_wr;                                 // accepted command write
	logic       busy_q;
	logic       presence_q;
	logic [7:0] rdata_q;

	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	assign cmd_wr = wb_req && wb_we && (wb_adr == REG_CMD) && !busy_q;  // dropped while busy

	// ************************************************
	// bus handshake and status
	// ************************************************
	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			wb_ack     <= 1'b0;
			cmd_start  <= 1'b0;
			busy_q     <= 1'b0;
			presence_q <= 1'b0;
			rdata_q    <= 8'h00;
		end else begin
			wb_ack    <= wb_req;                        // single cycle ack
			cmd_start <= cmd_wr;
			if (cmd_wr) begin
				busy_q <= 1'b1;
			end else if (rsp.done) begin
				busy_q     <= 1'b0;                     // op finished
				presence_q <= rsp.presence;
				rdata_q    <= rsp.rdata;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cmd_wr)
			cmd <= ow_cmd_t'(wb_dat_w[9:0]);            // op and byte in low bits
	end

	// read mux, master holds adr until ack
	always_comb begin
		wb_dat_r = 32'h0000_0000;
		case (wb_adr)
			REG_CMD:    wb_dat_r[9:0] = cmd;
			REG_STATUS: wb_dat_r[1:0] = {presence_q, busy_q};
			REG_RDATA:  wb_dat_r[7:0] = rdata_q;
			default:    wb_dat_r      = 32'h0000_0000;  // unused address
		endcase
	end

	a_ack_in_cycle: assert property (@(posedge sys_clk) disable iff (master_rst)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack outside of a bus cycle");

endmodule

// ==== verilog/uart_rx_dual_baud.sv ====
`timescale 1ns/1ps

module uart_rx_dual_baud #(
	parameter int CLK_FREQ  = 960000,
	parameter int BAUD_FAST = 96000,
	parameter int BAUD_SLOW = 48000
) (
	input  logic       sys_clk,
	input  logic       master_rst,
	input  logic       slow_baud,                       // same rate as the transmitter
	input  logic       rxd,                             // echo from the open drain bus
	output logic       rx_valid,                        // pulse at mid stop bit
	output logic [7:0] rx_byte
);

	localparam int BIT_FAST = CLK_FREQ / BAUD_FAST;
	localparam int BIT_SLOW = CLK_FREQ / BAUD_SLOW;
	localparam int CNT_W    = $clog2(BIT_SLOW) + 1;

	localparam logic [CNT_W-1:0] LAST_FAST = CNT_W'(BIT_FAST - 1);
	localparam logic [CNT_W-1:0] LAST_SLOW = CNT_W'(BIT_SLOW - 1);
	localparam logic [CNT_W-1:0] HALF_FAST = CNT_W'(BIT_FAST / 2);
	localparam logic [CNT_W-1:0] HALF_SLOW = CNT_W'(BIT_SLOW / 2);

	logic [1:0]       rxd_sync;                         // two flop synchronizer
	logic             rxd_s;                            // synchronized rxd
	logic             rxd_prev;                         // for edge detect
	logic             start_edge;
	logic             receiving;
	logic             slow_q;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;                          // 0 start, 1..8 data, 9 stop
	logic [7:0]       shift_q;
	logic [CNT_W-1:0] bit_last;
	logic [CNT_W-1:0] bit_half;
	logic             bit_end;
	logic             bit_mid;

	assign rxd_s      = rxd_sync[1];
	assign start_edge = !receiving && rxd_prev && !rxd_s;   // falling edge while idle
	assign bit_last   = slow_q ? LAST_SLOW : LAST_FAST;
	assign bit_half   = slow_q ? HALF_SLOW : HALF_FAST;
	assign bit_end    = clk_cnt == bit_last;
	assign bit_mid    = receiving && (clk_cnt == bit_half);

	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			rxd_sync <= 2'b11;                          // line idles high
			rxd_prev <= 1'b1;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rxd_prev <= rxd_s;
		end
	end

	// ************************************************
	// frame sequencing
	// ************************************************
	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			receiving <= 1'b0;
			rx_valid  <= 1'b0;
			clk_cnt   <= '0;
			bit_cnt   <= 4'd0;
		end else begin
			rx_valid <= 1'b0;
			if (start_edge) begin
				receiving <= 1'b1;
				clk_cnt   <= '0;
				bit_cnt   <= 4'd0;
			end else if (receiving) begin
				if (bit_end) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 4'd1;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
				if (bit_mid && (bit_cnt == 4'd0) && rxd_s)
					receiving <= 1'b0;                  // glitch, start bit gone
				else if (bit_mid && (bit_cnt == 4'd9)) begin
					receiving <= 1'b0;
					rx_valid  <= rxd_s;                 // low stop bit drops the frame
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start_edge)
			slow_q <= slow_baud;                        // rate fixed for this frame
		if (bit_mid && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8))
			shift_q <= {rxd_s, shift_q[7:1]};           // lsb arrives first
		if (bit_mid && (bit_cnt == 4'd9))
			rx_byte <= shift_q;
	end

endmodule

// ==== verilog/uart_tx_dual_baud.sv ====
`timescale 1ns/1ps

module uart_tx_dual_baud #(
	parameter int CLK_FREQ  = 960000,
	parameter int BAUD_FAST = 96000,
	parameter int BAUD_SLOW = 48000
) (
	input  logic                     sys_clk,
	input  logic                     master_rst,
	input  logic                     tx_start,      // one cycle send request
	input  logic                     slow_baud,     // 1 selects the slow rate
	input  ow_uart_pkg::uart_frame_t tx_frame,      // start, data, stop
	output logic                     tx_done,       // half a bit into the stop bit
	output logic                     txd
);
	import ow_uart_pkg::*;

	localparam int BIT_FAST = CLK_FREQ / BAUD_FAST;     // clocks per fast bit
	localparam int BIT_SLOW = CLK_FREQ / BAUD_SLOW;     // clocks per slow bit
	localparam int CNT_W    = $clog2(BIT_SLOW) + 1;

	localparam logic [CNT_W-1:0] LAST_FAST = CNT_W'(BIT_FAST - 1);
	localparam logic [CNT_W-1:0] LAST_SLOW = CNT_W'(BIT_SLOW - 1);
	localparam logic [CNT_W-1:0] HALF_FAST = CNT_W'(BIT_FAST / 2);
	localparam logic [CNT_W-1:0] HALF_SLOW = CNT_W'(BIT_SLOW / 2);

	logic             sending;                          // frame in progress
	logic             slow_q;                           // rate latched at start
	uart_frame_t      frame_q;                          // frame buffer
	logic [CNT_W-1:0] clk_cnt;                          // clocks within a bit
	logic [3:0]       bit_cnt;                          // bit index 0..9
	logic [CNT_W-1:0] bit_last;
	logic [CNT_W-1:0] bit_half;
	logic             bit_end;
	logic             frame_end;

	assign bit_last  = slow_q ? LAST_SLOW : LAST_FAST;
	assign bit_half  = slow_q ? HALF_SLOW : HALF_FAST;
	assign bit_end   = clk_cnt == bit_last;
	assign frame_end = sending && (bit_cnt == 4'd9) && (clk_cnt == bit_half);

	// ************************************************
	// bit timing
	// ************************************************
	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			sending <= 1'b0;
			tx_done <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= 4'd0;
		end else if (tx_start) begin
			sending <= 1'b1;                            // restart counters on request
			tx_done <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= 4'd0;
		end else if (frame_end) begin
			sending <= 1'b0;                            // mid stop bit, line already high
			tx_done <= 1'b1;
		end else begin
			tx_done <= 1'b0;
			if (sending) begin
				if (bit_end) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 4'd1;          // next bit
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= '0;
				bit_cnt <= 4'd0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_start) begin
			frame_q <= tx_frame;                        // hold frame for ten bits
			slow_q  <= slow_baud;
		end
	end

	// serial output, lsb first
	always_ff @(posedge sys_clk) begin
		if (master_rst)
			txd <= 1'b1;
		else if (sending)
			txd <= frame_q[bit_cnt];
		else
			txd <= 1'b1;                                // idle line high
	end

	a_idle_high: assert property (@(posedge sys_clk) disable iff (master_rst)
		!sending |-> txd)
		else $error("txd low while transmitter idle");

endmodule
